// File: sim/score_golden.txt
// ten glyph lines, digits 0 to 9: rows 0..9 of 30 bits each, in hex
// then vector lines: score, then its digits from ten-thousands down to units
00000000 001FFE00 00E001C0 07E001F8 07E001F8 07E001F8 07E001F8 00E001C0 001FFE00 00000000
00000000 001FF000 00FFF000 07E3F000 0003F000 0003F000 0003F000 0003F000 07FFFFF8 00000000
00000000 001FFE00 00FC0FC0 00E00FC0 00007E00 0003F000 001F8000 00FC01C0 00FFFFC0 00000000
00000000 00FFFE00 00E00FC0 00000FC0 00000E00 001FFFC0 00000FC0 00E00FC0 001FFE00 00000000
00000000 00000E00 00007E00 00038E00 001C0E00 00E00E00 00FFFFF8 00000E00 00000E00 00000000
00000000 00FFFFC0 00E001C0 00E00000 00FFFFC0 00FFFFC0 000001C0 00E001C0 00FFFFC0 00000000
00000000 00FFFFC0 00E001C0 00E00000 00E00000 00FFFFC0 00E001C0 00E001C0 00FFFFC0 00000000
00000000 00FFFFC0 00E001C0 00E001C0 000001C0 000001C0 000001C0 000001C0 000001C0 00000000
00000000 001FFE00 00E001C0 00E001C0 001FFE00 00E001C0 00E001C0 00E001C0 001FFE00 00000000
00000000 00FFFFC0 00E001C0 00E001C0 00FFFFC0 000001C0 000001C0 00E001C0 00FFFFC0 00000000
0000 0 0 0 0 0
0009 0 0 0 0 9
000A 0 0 0 1 0
0063 0 0 0 9 9
270F 0 9 9 9 9
2710 1 0 0 0 0
FFFF 6 5 5 3 5
3039 1 2 3 4 5
D431 5 4 3 2 1
03E8 0 1 0 0 0

// File: build.f
design/score_pkg.sv
design/digit_font.sv
design/score_bcd.sv
design/score_bitmap.sv
design/score_display.sv
sim/score_display_assert.sv
sim/score_checker.sv
sim/tb_score_display.sv

// File: Makefile
TOP = tb_score_display

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)
	verilator --lint-only design/score_pkg.sv design/digit_font.sv design/score_bcd.sv \
		design/score_bitmap.sv design/score_display.sv --top-module score_display

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "\*\* PASS \*\*" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/tb_score_display.sv
module tb_score_display import score_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int VEC_COUNT  = 10;
    localparam int GOLD_WORDS = 100 + VEC_COUNT*6; // glyph words, then six words per vector.

    logic        clk;
    logic        rst_n;
    score_t      score;
    bitmap_row_t rows [ROW_COUNT];
    logic        exp_valid;
    digit_t      exp_digits [DIGIT_COUNT];
    glyph_row_t  glyph_tab [10][ROW_COUNT];
    logic [31:0] gold [GOLD_WORDS];
    int          seed;
    int          base_checks;
    int          base_errors;
    logic [19:0] dg;

    score_display dut (
        .clk   (clk),
        .rst_n (rst_n),
        .score (score),
        .rows  (rows)
    );

    score_checker chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .glyph_tab  (glyph_tab),
        .exp_valid  (exp_valid),
        .exp_digits (exp_digits),
        .rows       (rows)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // packed nibbles, ten-thousands in the top nibble.
    function automatic logic [19:0] decimal_digits(input int v);
        return {4'(v / 10000 % 10), 4'(v / 1000 % 10), 4'(v / 100 % 10),
                4'(v / 10 % 10), 4'(v % 10)};
    endfunction

    task automatic apply_score(input score_t s, input logic [19:0] d);
        @(posedge clk);
        score     <= s;
        exp_valid <= 1'b1;
        for (int i = 0; i < DIGIT_COUNT; i++) begin
            exp_digits[i] <= d[(DIGIT_COUNT-1-i)*4 +: 4];
        end
    endtask

    task automatic wait_checks(input int target);
        int waited;
        waited = 0;
        while (chk.check_count < target) begin
            @(posedge clk);
            waited++;
            if (waited > 50) begin
                $display("timeout: checker stuck at %0d of %0d checks", chk.check_count, target);
                $display("** FAIL **");
                $finish;
            end
        end
    endtask

    task automatic start_test();
        base_checks = chk.check_count;
        base_errors = chk.err_count;
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d checks, %0d errors", name,
                 chk.check_count - base_checks, chk.err_count - base_errors);
    endtask

    initial begin
        rst_n     = 1'b0;
        score     = '0;
        exp_valid = 1'b0;
        for (int i = 0; i < DIGIT_COUNT; i++) begin
            exp_digits[i] = '0;
        end
        seed = 32'h5e66;
        $readmemh("sim/score_golden.txt", gold);
        for (int g = 0; g < 10; g++) begin
            for (int r = 0; r < ROW_COUNT; r++) begin
                glyph_tab[g][r] = gold[g*ROW_COUNT + r][GLYPH_W-1:0];
            end
        end

        // ########################################
        // tests
        // ########################################

        start_test();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait_checks(base_checks + 4);
        report_test("reset");

        start_test();
        for (int v = 0; v < VEC_COUNT; v++) begin
            for (int k = 0; k < DIGIT_COUNT; k++) begin
                dg[(DIGIT_COUNT-1-k)*4 +: 4] = gold[100 + v*6 + 1 + k][3:0];
            end
            apply_score(gold[100 + v*6][SCORE_W-1:0], dg);
            wait_checks(chk.check_count + 3); // held long enough to reach the rows.
        end
        report_test("golden vectors");

        start_test();
        for (int n = 0; n < 20; n++) begin
            score_t s;
            s = score_t'($random(seed));
            apply_score(s, decimal_digits(int'(s)));
        end
        wait_checks(base_checks + 23);
        report_test("random burst");

        start_test();
        apply_score(16'd4321, decimal_digits(4321));
        @(posedge clk);
        rst_n <= 1'b0; // mid-stream reset.
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        apply_score(16'd808, decimal_digits(808));
        wait_checks(chk.check_count + 3);
        report_test("mid-stream reset");

        $display("checks %0d, errors %0d", chk.check_count, chk.err_count);
        if (chk.err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sim/score_checker.sv
module score_checker import score_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input glyph_row_t  glyph_tab [10][ROW_COUNT],
    input logic        exp_valid,
    input digit_t      exp_digits [DIGIT_COUNT],
    input bitmap_row_t rows [ROW_COUNT]
);

    timeunit 1ns;
    timeprecision 1ps;

    int     check_count = 0;
    int     err_count = 0;
    logic   s1_valid = 1'b0;
    logic   s2_valid = 1'b0;
    logic   s2_blank = 1'b0;
    digit_t s1_digits [DIGIT_COUNT];
    digit_t s2_digits [DIGIT_COUNT];

    // ########################################
    // expectation pipeline, two stages deep
    // ########################################

    always @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b1; // the bcd stage holds zero digits after reset.
            s2_valid <= 1'b1;
            s2_blank <= 1'b1; // the row stage is dark, not the glyph of zero.
            for (int d = 0; d < DIGIT_COUNT; d++) begin
                s1_digits[d] <= '0;
                s2_digits[d] <= '0;
            end
        end else begin
            s1_valid  <= exp_valid;
            s1_digits <= exp_digits;
            s2_valid  <= s1_valid;
            s2_blank  <= 1'b0;
            s2_digits <= s1_digits;
        end
    end

    // rows are settled on the falling edge.
    always @(negedge clk) begin : compare_rows
        bitmap_row_t exp_row;
        if (s2_valid) begin
            for (int r = 0; r < ROW_COUNT; r++) begin
                exp_row = '0;
                if (!s2_blank) begin
                    for (int d = 0; d < DIGIT_COUNT; d++) begin
                        exp_row[FIRST_MSB - d*DIGIT_PITCH -: CELL_W] =
                            glyph_tab[s2_digits[d]][r][CELL_W-1:0];
                    end
                end
                if (rows[r] !== exp_row) begin
                    $display("ERROR %0t ns: row %0d is %h, expected %h",
                             $time, r, rows[r], exp_row);
                    err_count++;
                end
            end
            check_count++;
        end
    end

endmodule

// File: sim/score_display_assert.sv
module score_display_assert import score_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input bitmap_row_t rows [ROW_COUNT],
    input digit_t      digits [DIGIT_COUNT]
);

    timeunit 1ns;
    timeprecision 1ps;

    function automatic bitmap_row_t window_mask();
        bitmap_row_t m;
        m = '0;
        for (int d = 0; d < DIGIT_COUNT; d++) begin
            m[FIRST_MSB - d*DIGIT_PITCH -: CELL_W] = '1;
        end
        return m;
    endfunction

    localparam bitmap_row_t WINDOWS = window_mask();

    for (genvar r = 0; r < ROW_COUNT; r++) begin : g_row
        assert property (@(posedge clk) !rst_n |=> rows[r] == '0)
            else $error("row %0d not cleared by reset", r);
        assert property (@(posedge clk) disable iff (!rst_n) (rows[r] & ~WINDOWS) == '0)
            else $error("row %0d has bits lit outside the digit windows", r);
    end

    for (genvar d = 0; d < DIGIT_COUNT; d++) begin : g_digit
        assert property (@(posedge clk) disable iff (!rst_n) digits[d] <= 4'd9)
            else $error("digit %0d is not decimal", d);
    end

endmodule

bind score_display score_display_assert u_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .rows   (rows),
    .digits (digits)
);

// File: design/score_display.sv
module score_display import score_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  score_t      score,
    output bitmap_row_t rows [ROW_COUNT]
);

    digit_t digits [DIGIT_COUNT]; // ten-thousands at index 0.

    // two register stages, so rows follow score by two clocks.
    score_bcd u_bcd (
        .clk    (clk),
        .rst_n  (rst_n),
        .score  (score),
        .digits (digits)
    );

    score_bitmap u_bitmap (
        .clk    (clk),
        .rst_n  (rst_n),
        .digits (digits),
        .rows   (rows)
    );

endmodule

// File: design/score_bitmap.sv
module score_bitmap import score_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  digit_t      digits [DIGIT_COUNT],
    output bitmap_row_t rows [ROW_COUNT]
);

    glyph_row_t  glyphs [DIGIT_COUNT][ROW_COUNT];
    bitmap_row_t next_rows [ROW_COUNT];

    // ########################################
    // one glyph lookup per digit position
    // ########################################

    for (genvar g = 0; g < DIGIT_COUNT; g++) begin : g_font
        digit_font u_font (
            .digit (digits[g]),
            .glyph (glyphs[g])
        );
    end

    // ########################################
    // placement into the row windows
    // ########################################

    always_comb begin
        for (int r = 0; r < ROW_COUNT; r++) begin
            next_rows[r] = '0; // gaps between windows and both margins stay dark.
            for (int d = 0; d < DIGIT_COUNT; d++) begin
                next_rows[r][FIRST_MSB - d*DIGIT_PITCH -: CELL_W] = glyphs[d][r][CELL_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < ROW_COUNT; r++) begin
                rows[r] <= '0;
            end
        end else begin
            rows <= next_rows;
        end
    end

endmodule

// File: design/score_bcd.sv
module score_bcd import score_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  score_t score,
    output digit_t digits [DIGIT_COUNT]
);

    logic [DIGIT_COUNT*4-1:0] bcd; // packed nibbles, units in the low nibble.

    // ########################################
    // shift-and-add-3, fully unrolled
    // ########################################

    always_comb begin
        bcd = '0;
        for (int i = SCORE_W - 1; i >= 0; i--) begin
            for (int d = 0; d < DIGIT_COUNT; d++) begin
                if (bcd[d*4 +: 4] > 4'd4) begin
                    bcd[d*4 +: 4] = bcd[d*4 +: 4] + 4'd3; // corrects before the doubling.
                end
            end
            bcd = {bcd[DIGIT_COUNT*4-2:0], score[i]};
        end
    end

    // the top nibble never overflows since 65535 fits in five digits.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int d = 0; d < DIGIT_COUNT; d++) begin
                digits[d] <= '0;
            end
        end else begin
            for (int d = 0; d < DIGIT_COUNT; d++) begin
                digits[d] <= bcd[(DIGIT_COUNT-1-d)*4 +: 4]; // index 0 gets the top nibble.
            end
        end
    end

endmodule

// File: design/digit_font.sv
module digit_font import score_pkg::*; (
    input  digit_t     digit,
    output glyph_row_t glyph [ROW_COUNT]
);

    // rows 0 and 9 stay blank for every digit.
    always_comb begin
        for (int r = 0; r < ROW_COUNT; r++) begin
            glyph[r] = '0;
        end
        case (digit)
            4'd0: begin
                glyph[1] = 30'b000000000111111111111000000000;
                glyph[2] = 30'b000000111000000000000111000000;
                glyph[3] = 30'b000111111000000000000111111000;
                glyph[4] = 30'b000111111000000000000111111000;
                glyph[5] = 30'b000111111000000000000111111000;
                glyph[6] = 30'b000111111000000000000111111000;
                glyph[7] = 30'b000000111000000000000111000000;
                glyph[8] = 30'b000000000111111111111000000000;
            end
            4'd1: begin
                glyph[1] = 30'b000000000111111111000000000000;
                glyph[2] = 30'b000000111111111111000000000000;
                glyph[3] = 30'b000111111000111111000000000000;
                glyph[4] = 30'b000000000000111111000000000000;
                glyph[5] = 30'b000000000000111111000000000000;
                glyph[6] = 30'b000000000000111111000000000000;
                glyph[7] = 30'b000000000000111111000000000000;
                glyph[8] = 30'b000111111111111111111111111000;
            end
            4'd2: begin
                glyph[1] = 30'b000000000111111111111000000000;
                glyph[2] = 30'b000000111111000000111111000000;
                glyph[3] = 30'b000000111000000000111111000000;
                glyph[4] = 30'b000000000000000111111000000000;
                glyph[5] = 30'b000000000000111111000000000000;
                glyph[6] = 30'b000000000111111000000000000000;
                glyph[7] = 30'b000000111111000000000111000000;
                glyph[8] = 30'b000000111111111111111111000000;
            end
            4'd3: begin
                glyph[1] = 30'b000000111111111111111000000000;
                glyph[2] = 30'b000000111000000000111111000000;
                glyph[3] = 30'b000000000000000000111111000000;
                glyph[4] = 30'b000000000000000000111000000000;
                glyph[5] = 30'b000000000111111111111111000000;
                glyph[6] = 30'b000000000000000000111111000000;
                glyph[7] = 30'b000000111000000000111111000000;
                glyph[8] = 30'b000000000111111111111000000000;
            end
            4'd4: begin
                glyph[1] = 30'b000000000000000000111000000000;
                glyph[2] = 30'b000000000000000111111000000000;
                glyph[3] = 30'b000000000000111000111000000000;
                glyph[4] = 30'b000000000111000000111000000000;
                glyph[5] = 30'b000000111000000000111000000000;
                glyph[6] = 30'b000000111111111111111111111000;
                glyph[7] = 30'b000000000000000000111000000000;
                glyph[8] = 30'b000000000000000000111000000000;
            end
            4'd5: begin
                glyph[1] = 30'b000000111111111111111111000000;
                glyph[2] = 30'b000000111000000000000111000000;
                glyph[3] = 30'b000000111000000000000000000000;
                glyph[4] = 30'b000000111111111111111111000000;
                glyph[5] = 30'b000000111111111111111111000000;
                glyph[6] = 30'b000000000000000000000111000000;
                glyph[7] = 30'b000000111000000000000111000000;
                glyph[8] = 30'b000000111111111111111111000000;
            end
            4'd6: begin
                glyph[1] = 30'b000000111111111111111111000000;
                glyph[2] = 30'b000000111000000000000111000000;
                glyph[3] = 30'b000000111000000000000000000000;
                glyph[4] = 30'b000000111000000000000000000000;
                glyph[5] = 30'b000000111111111111111111000000;
                glyph[6] = 30'b000000111000000000000111000000;
                glyph[7] = 30'b000000111000000000000111000000;
                glyph[8] = 30'b000000111111111111111111000000;
            end
            4'd7: begin
                glyph[1] = 30'b000000111111111111111111000000;
                glyph[2] = 30'b000000111000000000000111000000;
                glyph[3] = 30'b000000111000000000000111000000;
                glyph[4] = 30'b000000000000000000000111000000;
                glyph[5] = 30'b000000000000000000000111000000;
                glyph[6] = 30'b000000000000000000000111000000;
                glyph[7] = 30'b000000000000000000000111000000;
                glyph[8] = 30'b000000000000000000000111000000;
            end
            4'd8: begin
                glyph[1] = 30'b000000000111111111111000000000;
                glyph[2] = 30'b000000111000000000000111000000;
                glyph[3] = 30'b000000111000000000000111000000;
                glyph[4] = 30'b000000000111111111111000000000;
                glyph[5] = 30'b000000111000000000000111000000;
                glyph[6] = 30'b000000111000000000000111000000;
                glyph[7] = 30'b000000111000000000000111000000;
                glyph[8] = 30'b000000000111111111111000000000;
            end
            4'd9: begin
                glyph[1] = 30'b000000111111111111111111000000;
                glyph[2] = 30'b000000111000000000000111000000;
                glyph[3] = 30'b000000111000000000000111000000;
                glyph[4] = 30'b000000111111111111111111000000;
                glyph[5] = 30'b000000000000000000000111000000;
                glyph[6] = 30'b000000000000000000000111000000;
                glyph[7] = 30'b000000111000000000000111000000;
                glyph[8] = 30'b000000111111111111111111000000;
            end
            default: ; // non-decimal codes draw nothing.
        endcase
    end

endmodule

// File: design/score_pkg.sv
package score_pkg;

    // ########################################
    // sizes
    // ########################################

    localparam int SCORE_W     = 16;  // binary score width.
    localparam int DIGIT_COUNT = 5;   // decimal digits shown, ten-thousands first.
    localparam int ROW_COUNT   = 10;  // glyph height in pixel rows.
    localparam int ROW_W       = 192; // one full bitmap row.
    localparam int GLYPH_W     = 30;  // stored width of a glyph row.
    localparam int CELL_W      = 28;  // only the low bits of a glyph row are drawn.

    // ########################################
    // digit windows
    // ########################################

    // digit n occupies bits FIRST_MSB - n*DIGIT_PITCH downward, CELL_W bits wide.
    localparam int DIGIT_PITCH = 36;
    localparam int FIRST_MSB   = 183;

    // ########################################
    // types
    // ########################################

    typedef logic [SCORE_W-1:0] score_t;
    typedef logic [3:0]         digit_t;     // bcd code, 0 to 9 when valid.
    typedef logic [GLYPH_W-1:0] glyph_row_t;
    typedef logic [ROW_W-1:0]   bitmap_row_t;

endpackage
